// ==== flist.f ====
+incdir+rtl
rtl/sysblk_pkg.sv
rtl/sysblk_decode.sv
rtl/sysblk_execute.sv
rtl/clk_alive_counter.sv
rtl/sysblk_result.sv
rtl/sys_block_top.sv
verification/sys_block_props.sv
verification/sys_block_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A failed check ends the run through $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module sys_block_tb -f flist.f \
  -Mdir obj_dir -o sys_block_tb_sim

./obj_dir/sys_block_tb_sim

// ==== verification/sys_block_tb.sv ====
`timescale 1ns/10ps
`include "sysblk_settings.svh"

module sys_block_tb;

  localparam logic [1:0] kind_exact = 2'd0;
  localparam logic [1:0] kind_incr  = 2'd1;
  localparam logic [1:0] kind_const = 2'd2;

  // one bus access, the check on its read data and the idle time before it.
  typedef struct packed {
    logic        we;
    logic [3:0]  idx;
    logic [1:0]  sel;
    logic [15:0] wdat;
    logic [15:0] exp;
    logic [1:0]  kind;
    logic        gate1;
    logic [7:0]  gap;
  } entry_t;

  logic        aux_clk;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        mon0;
  logic        mon1;
  logic        mon1_gate;
  logic [63:0] debug_i;
  logic [63:0] debug_word;
  integer      seed;
  entry_t      tbl [$];
  logic        table_done;
  logic [15:0] last_rd [16];

  sys_block_top sys_block_top_i (
    .aux_clk   (aux_clk),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_sel_i  (wb_sel_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .mon_clk_i ({mon1, mon0}),
    .debug_i   (debug_i)
  );

  initial begin
    aux_clk = 1'b0;
    forever #2 aux_clk = ~aux_clk;
  end

  initial begin
    mon0 = 1'b0;
    forever #5 mon0 = ~mon0;
  end

  // the second monitored clock simply stops toggling while gated.
  initial begin
    mon1 = 1'b0;
    forever begin
      #4;
      if (!mon1_gate) begin
        mon1 = ~mon1;
      end
    end
  end

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                               input logic [15:0] new_val,
                                               input logic [1:0]  sel);
    logic [15:0] res;
    res = old_val;
    if (sel[0]) begin
      res[7:0] = new_val[7:0];
    end
    if (sel[1]) begin
      res[15:8] = new_val[15:8];
    end
    return res;
  endfunction

  task automatic add_entry(input logic we, input logic [3:0] idx, input logic [1:0] sel,
                           input logic [15:0] wdat, input logic [15:0] exp,
                           input logic [1:0] kind, input logic gate1, input logic [7:0] gap);
    entry_t e;
    e.we    = we;
    e.idx   = idx;
    e.sel   = sel;
    e.wdat  = wdat;
    e.exp   = exp;
    e.kind  = kind;
    e.gate1 = gate1;
    e.gap   = gap;
    tbl.push_back(e);
  endtask

  task automatic build_table;
    logic [15:0] scratch_model;
    scratch_model = 16'h0000;
    add_entry(1'b0, 4'd4, 2'b11, 16'h0000, scratch_model, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd0, 2'b11, 16'h0000, `SYSBLK_BOARD_ID, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd1, 2'b11, 16'h0000, `SYSBLK_REV_MAJOR, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd2, 2'b11, 16'h0000, `SYSBLK_REV_MINOR, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd3, 2'b11, 16'h0000, `SYSBLK_REV_RCS, kind_exact, 1'b0, 8'd0);
    // byte lane writes to the scratchpad, each read back.
    scratch_model = merge_bytes(scratch_model, 16'h1234, 2'b11);
    add_entry(1'b1, 4'd4, 2'b11, 16'h1234, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd4, 2'b11, 16'h0000, scratch_model, kind_exact, 1'b0, 8'd0);
    scratch_model = merge_bytes(scratch_model, 16'habcd, 2'b01);
    add_entry(1'b1, 4'd4, 2'b01, 16'habcd, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd4, 2'b11, 16'h0000, scratch_model, kind_exact, 1'b0, 8'd0);
    scratch_model = merge_bytes(scratch_model, 16'h5a77, 2'b10);
    add_entry(1'b1, 4'd4, 2'b10, 16'h5a77, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd4, 2'b11, 16'h0000, scratch_model, kind_exact, 1'b0, 8'd0);
    scratch_model = merge_bytes(scratch_model, 16'hffff, 2'b00);
    add_entry(1'b1, 4'd4, 2'b00, 16'hffff, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd4, 2'b11, 16'h0000, scratch_model, kind_exact, 1'b0, 8'd0);
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 4'(7 + i), 2'b11, 16'h0000, debug_word[63 - 16 * i -: 16],
                kind_exact, 1'b0, 8'd0);
    end
    for (int i = 11; i < 16; i++) begin
      add_entry(1'b0, 4'(i), 2'b11, 16'h0000, 16'h0000, kind_exact, 1'b0, 8'd0);
    end
    add_entry(1'b1, 4'd0, 2'b11, 16'h1111, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd0, 2'b11, 16'h0000, `SYSBLK_BOARD_ID, kind_exact, 1'b0, 8'd0);
    add_entry(1'b1, 4'd9, 2'b11, 16'h2222, 16'h0000, kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd9, 2'b11, 16'h0000, debug_word[31:16], kind_exact, 1'b0, 8'd0);
    add_entry(1'b0, 4'd5, 2'b11, 16'h0000, 16'h0000, kind_incr, 1'b0, 8'd0);
    add_entry(1'b0, 4'd5, 2'b11, 16'h0000, 16'h0000, kind_incr, 1'b0, 8'd20);
    // the gated phase of the second monitored clock, then its restart.
    add_entry(1'b0, 4'd6, 2'b11, 16'h0000, 16'h0000, kind_incr, 1'b1, 8'd10);
    add_entry(1'b0, 4'd6, 2'b11, 16'h0000, 16'h0000, kind_const, 1'b1, 8'd20);
    add_entry(1'b0, 4'd6, 2'b11, 16'h0000, 16'h0000, kind_incr, 1'b0, 8'd20);
  endtask

  task automatic fail_value(input string what, input logic [15:0] got,
                            input string relation, input logic [15:0] ref_val);
    $display("ERR %0t: %s read %h, %s %h", $time, what, got, relation, ref_val);
    $display("tests failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_read(input int n, input entry_t e, input logic [15:0] rd);
    string what;
    what = $sformatf("entry %0d index %0d", n, e.idx);
    case (e.kind)
      kind_incr: begin
        assert (rd > last_rd[e.idx]) else fail_value(what, rd, "expected above", last_rd[e.idx]);
      end
      kind_const: begin
        assert (rd == last_rd[e.idx]) else fail_value(what, rd, "expected still", last_rd[e.idx]);
      end
      default: begin
        assert (rd == e.exp) else fail_value(what, rd, "expected", e.exp);
      end
    endcase
  endtask

  task automatic run_entry(input int n, input entry_t e);
    logic [15:0] rd;
    mon1_gate = e.gate1;
    repeat (e.gap) @(posedge aux_clk);
    @(posedge aux_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= e.we;
    wb_sel_i <= e.sel;
    wb_adr_i <= {27'h0, e.idx, 1'b0};
    wb_dat_i <= e.wdat;
    // read data is taken at the falling edge, half a cycle clear of the flops.
    do begin
      @(negedge aux_clk);
    end while (!wb_ack_o);
    rd = wb_dat_o;
    @(posedge aux_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!e.we) begin
      check_read(n, e, rd);
      last_rd[e.idx] = rd;
    end
  endtask

  task automatic check_held_strobe;
    int   acks;
    logic prev_ack;
    acks     = 0;
    prev_ack = 1'b0;
    @(posedge aux_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_sel_i <= 2'b11;
    wb_adr_i <= {27'h0, 4'd1, 1'b0};
    repeat (8) begin
      @(negedge aux_clk);
      if (wb_ack_o) begin
        acks++;
        assert (!prev_ack) else fail_plain("ack stayed high for two cycles under a held strobe");
        assert (wb_dat_o == `SYSBLK_REV_MAJOR)
          else fail_value("held strobe", wb_dat_o, "expected", `SYSBLK_REV_MAJOR);
      end
      prev_ack = wb_ack_o;
    end
    @(posedge aux_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    assert (acks == 4) else fail_value("held strobe ack count", 16'(acks), "expected", 16'd4);
  endtask

  initial begin
    table_done = 1'b0;
    mon1_gate  = 1'b0;
    wb_rst_i   = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_sel_i   = 2'b00;
    wb_adr_i   = 32'h0000_0000;
    wb_dat_i   = 16'h0000;
    seed       = 32'hd1c43ec4;
    debug_word = {$random(seed), $random(seed)};
    debug_i    = debug_word;
    for (int i = 0; i < 16; i++) begin
      last_rd[i] = 16'h0000;
    end
    build_table();
    table_done = 1'b1;
    repeat (4) @(posedge aux_clk);
    wb_rst_i <= 1'b0;
    foreach (tbl[n]) begin
      run_entry(n, tbl[n]);
    end
    check_held_strobe();
    $display("all tests passed");
    $finish;
  end

  // the cycle budget grows with the number of table entries.
  initial begin
    int limit;
    wait (table_done);
    limit = 40 * tbl.size() + 100;
    repeat (limit) @(posedge aux_clk);
    $display("watchdog expired after %0d cycles with accesses still pending", limit);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== verification/sys_block_props.sv ====
`timescale 1ns/10ps

module sys_block_props (
  input logic aux_clk,
  input logic wb_rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i
);

  logic accept;

  assign accept = cyc_i & stb_i & ~ack_i;

  // the acknowledge is a single-cycle pulse.
  ack_single: assert property (@(posedge aux_clk) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else $error("ack stayed high for two cycles");

  ack_follows: assert property (@(posedge aux_clk) disable iff (wb_rst_i)
    accept |=> ack_i)
    else $error("accepted strobe got no ack on the next cycle");

  // no ack appears without an accepted strobe before it.
  ack_only_accepted: assert property (@(posedge aux_clk) disable iff (wb_rst_i)
    !accept |=> !ack_i)
    else $error("ack without an accepted strobe");

endmodule

bind sys_block_top sys_block_props sys_block_props_i (
  .aux_clk  (aux_clk),
  .wb_rst_i (wb_rst_i),
  .cyc_i    (wb_cyc_i),
  .stb_i    (wb_stb_i),
  .ack_i    (wb_ack_o)
);

// ==== rtl/sys_block_top.sv ====
`timescale 1ns/10ps
`include "sysblk_settings.svh"

module sys_block_top (
  input  logic        aux_clk,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic [1:0]  mon_clk_i,
  input  logic [63:0] debug_i
);

  import sysblk_pkg::*;

  access_t                    dec_acc;
  access_t                    rd_acc;
  logic [15:0]                scratch;
  logic [`SYSBLK_ALIVE_W-1:0] alive0;
  logic [`SYSBLK_ALIVE_W-1:0] alive1;

  sysblk_decode decode_i (
    .adr_i (wb_adr_i),
    .we_i  (wb_we_i),
    .sel_i (wb_sel_i),
    .acc_o (dec_acc)
  );

  sysblk_execute execute_i (
    .aux_clk   (aux_clk),
    .wb_rst_i  (wb_rst_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .dat_i     (wb_dat_i),
    .acc_i     (dec_acc),
    .ack_o     (wb_ack_o),
    .rd_acc_o  (rd_acc),
    .scratch_o (scratch)
  );

  // one counter per monitored clock.
  clk_alive_counter alive0_i (
    .aux_clk   (aux_clk),
    .wb_rst_i  (wb_rst_i),
    .mon_clk_i (mon_clk_i[0]),
    .count_o   (alive0)
  );

  clk_alive_counter alive1_i (
    .aux_clk   (aux_clk),
    .wb_rst_i  (wb_rst_i),
    .mon_clk_i (mon_clk_i[1]),
    .count_o   (alive1)
  );

  sysblk_result result_i (
    .rd_acc_i  (rd_acc),
    .scratch_i (scratch),
    .alive0_i  (alive0),
    .alive1_i  (alive1),
    .debug_i   (debug_i),
    .dat_o     (wb_dat_o)
  );

endmodule

// ==== rtl/sysblk_result.sv ====
`timescale 1ns/10ps
`include "sysblk_settings.svh"

module sysblk_result (
  input  sysblk_pkg::access_t        rd_acc_i,
  input  logic [15:0]                scratch_i,
  input  logic [`SYSBLK_ALIVE_W-1:0] alive0_i,
  input  logic [`SYSBLK_ALIVE_W-1:0] alive1_i,
  input  logic [63:0]                debug_i,
  output logic [15:0]                dat_o
);

  import sysblk_pkg::*;

  // the read word follows the latched index, so it holds steady while ack is high.
  always_comb begin
    dat_o = 16'h0000;
    if (rd_acc_i.mapped) begin
      case (rd_acc_i.reg_idx)
        reg_board_id: begin
          dat_o = `SYSBLK_BOARD_ID;
        end
        reg_rev_major: begin
          dat_o = `SYSBLK_REV_MAJOR;
        end
        reg_rev_minor: begin
          dat_o = `SYSBLK_REV_MINOR;
        end
        reg_rev_rcs: begin
          dat_o = `SYSBLK_REV_RCS;
        end
        reg_scratch: begin
          dat_o = scratch_i;
        end
        reg_alive0: begin
          dat_o = 16'(alive0_i);
        end
        reg_alive1: begin
          dat_o = 16'(alive1_i);
        end
        // debug slices come out from the top word down.
        reg_debug_3: begin
          dat_o = debug_i[63:48];
        end
        reg_debug_2: begin
          dat_o = debug_i[47:32];
        end
        reg_debug_1: begin
          dat_o = debug_i[31:16];
        end
        reg_debug_0: begin
          dat_o = debug_i[15:0];
        end
        default: begin
          dat_o = 16'h0000;
        end
      endcase
    end
  end

endmodule

// ==== rtl/clk_alive_counter.sv ====
`timescale 1ns/10ps
`include "sysblk_settings.svh"

module clk_alive_counter (
  input  logic                       aux_clk,
  input  logic                       wb_rst_i,
  input  logic                       mon_clk_i,
  output logic [`SYSBLK_ALIVE_W-1:0] count_o
);

  localparam int cnt_w = `SYSBLK_ALIVE_W;

  logic [1:0]       mon_rst_sync;
  logic             mon_rst;
  logic [cnt_w-1:0] bin_q;
  logic [cnt_w-1:0] bin_next;
  logic [cnt_w-1:0] gray_q;
  logic [cnt_w-1:0] gray_s1;
  logic [cnt_w-1:0] gray_s2;
  logic [cnt_w-1:0] count_q;

  function automatic logic [cnt_w-1:0] gray_to_bin(input logic [cnt_w-1:0] g);
    logic [cnt_w-1:0] b;
    b[cnt_w-1] = g[cnt_w-1];
    for (int i = cnt_w - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // bring the bus reset into the monitored domain.
  always_ff @(posedge mon_clk_i) begin
    mon_rst_sync <= {mon_rst_sync[0], wb_rst_i};
  end

  assign mon_rst  = mon_rst_sync[1];
  assign bin_next = bin_q + cnt_w'(1);

  // the gray word is registered so that only one bit moves per source edge.
  always_ff @(posedge mon_clk_i) begin
    if (mon_rst) begin
      bin_q  <= '0;
      gray_q <= '0;
    end else begin
      bin_q  <= bin_next;
      gray_q <= bin_next ^ (bin_next >> 1);
    end
  end

  // two flops cross into aux_clk, a third holds the decoded count.
  always_ff @(posedge aux_clk) begin
    if (wb_rst_i) begin
      gray_s1 <= '0;
      gray_s2 <= '0;
      count_q <= '0;
    end else begin
      gray_s1 <= gray_q;
      gray_s2 <= gray_s1;
      count_q <= gray_to_bin(gray_s2);
    end
  end

  assign count_o = count_q;

endmodule

// ==== rtl/sysblk_execute.sv ====
`timescale 1ns/10ps

module sysblk_execute (
  input  logic                aux_clk,
  input  logic                wb_rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic [15:0]         dat_i,
  input  sysblk_pkg::access_t acc_i,
  output logic                ack_o,
  output sysblk_pkg::access_t rd_acc_o,
  output logic [15:0]         scratch_o
);

  import sysblk_pkg::*;

  logic        ack_q;
  access_t     rd_acc_q;
  logic [15:0] scratch_q;
  logic        accept;

  // an access is taken only while no ack is pending, so a held strobe
  // is served every second cycle.
  assign accept = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge aux_clk) begin
    if (wb_rst_i) begin
      ack_q     <= 1'b0;
      rd_acc_q  <= acc_reset;
      scratch_q <= 16'h0000;
    end else begin
      ack_q <= accept;
      if (accept) begin
        rd_acc_q <= acc_i;
        if (acc_i.scratch_wr) begin
          if (acc_i.byte_en[0]) begin
            scratch_q[7:0] <= dat_i[7:0];
          end
          if (acc_i.byte_en[1]) begin
            scratch_q[15:8] <= dat_i[15:8];
          end
        end
      end
    end
  end

  assign ack_o     = ack_q;
  assign rd_acc_o  = rd_acc_q;
  assign scratch_o = scratch_q;

endmodule

// ==== rtl/sysblk_decode.sv ====
`timescale 1ns/10ps

module sysblk_decode (
  input  logic [31:0]         adr_i,
  input  logic                we_i,
  input  logic [1:0]          sel_i,
  output sysblk_pkg::access_t acc_o
);

  import sysblk_pkg::*;

  logic [3:0] idx;
  logic       is_mapped;
  logic       any_byte;
  logic       hit_scratch;

  // registers are 16 bits wide, so bit 0 is a byte offset and the index starts at bit 1.
  // bits above 4 are not decoded and the register file aliases across them.
  assign idx = adr_i[4:1];

  assign is_mapped   = (idx <= last_mapped_idx);
  assign any_byte    = |sel_i;
  assign hit_scratch = (idx == reg_scratch);

  always_comb begin
    acc_o.reg_idx    = reg_idx_e'(idx);
    acc_o.mapped     = is_mapped;
    // only the scratchpad takes writes, and only when a byte lane is enabled.
    acc_o.scratch_wr = we_i & hit_scratch & any_byte;
    acc_o.byte_en    = sel_i;
  end

endmodule

// ==== rtl/sysblk_pkg.sv ====
package sysblk_pkg;

  // register index as carried in address bits 4 to 1.
  // indices 11 to 15 have no name and read as zero.
  typedef enum logic [3:0] {
    reg_board_id  = 4'd0,
    reg_rev_major = 4'd1,
    reg_rev_minor = 4'd2,
    reg_rev_rcs   = 4'd3,
    reg_scratch   = 4'd4,
    reg_alive0    = 4'd5,
    reg_alive1    = 4'd6,
    reg_debug_3   = 4'd7,
    reg_debug_2   = 4'd8,
    reg_debug_1   = 4'd9,
    reg_debug_0   = 4'd10
  } reg_idx_e;

  // highest index that is backed by a register.
  localparam reg_idx_e last_mapped_idx = reg_debug_0;

  // one bus access after address decode.
  typedef struct packed {
    reg_idx_e   reg_idx;
    logic       mapped;
    logic       scratch_wr;
    logic [1:0] byte_en;
  } access_t;

  // read selection held after reset, which points at the board id.
  localparam access_t acc_reset = '{
    reg_idx:    reg_board_id,
    mapped:     1'b1,
    scratch_wr: 1'b0,
    byte_en:    2'b00
  };

endpackage

// ==== rtl/sysblk_settings.svh ====
`ifndef SYSBLK_SETTINGS_SVH
`define SYSBLK_SETTINGS_SVH

// identification words returned by registers 0 to 3.
`define SYSBLK_BOARD_ID  16'hdead
`define SYSBLK_REV_MAJOR 16'haaaa
`define SYSBLK_REV_MINOR 16'hbbbb
`define SYSBLK_REV_RCS   16'hcccc

// width of each clock-alive counter, which fills one bus word.
`define SYSBLK_ALIVE_W 16

`endif
